// File: enc_period.f
src/enc_types_pkg.sv
src/enc_report_pkg.sv
src/enc_input_sync.sv
src/enc_quad_decoder.sv
src/enc_period_counter.sv
src/enc_period_report.sv
src/enc_period_top.sv
+incdir+testbench
testbench/enc_period_tb.sv

// File: Makefile
# Verilator build and run for the encoder period testbench

VERILATOR ?= verilator
TOP       ?= enc_period_tb
FILELIST  ?= enc_period.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

test: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test: simulation passed"; \
	else \
		echo "test: simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/enc_period_stim.txt
# columns: a b hold flag period dir dir_changed overflowed position
# hold 0 = random hold, flag 1 = check word, 2 = word unchecked, period 0 = from holds
1 0 10 2 0 0 0 0 1
1 1 10 0 0 0 0 0 2
0 1 10 0 0 0 0 0 3
0 0 10 0 0 0 0 0 4
1 0 12 1 40 0 0 0 5
1 1 0 0 0 0 0 0 6
0 1 0 0 0 0 0 0 7
0 0 0 0 0 0 0 0 8
1 0 0 1 0 0 0 0 9
1 1 0 0 0 0 0 0 10
0 1 0 0 0 0 0 0 11
0 0 0 0 0 0 0 0 12
1 0 10 1 0 0 0 0 13
1 1 10 0 0 0 0 0 14
0 1 10 0 0 0 0 0 15
0 0 10 0 0 0 0 0 16
# reversal, b now leads a
0 1 10 0 0 0 0 0 15
1 1 10 1 4194303 1 1 0 14
1 0 10 0 0 0 0 0 13
0 0 10 0 0 0 0 0 12
0 1 10 0 0 0 0 0 11
1 1 11 1 40 1 0 0 10
# standstill past the counter limit
1 0 11 0 0 0 0 0 9
0 0 11 0 0 0 0 0 8
0 1 4194400 0 0 0 0 0 7
1 1 10 1 4194303 1 0 1 6

// File: testbench/enc_period_checks.svh
// testbench helpers for the encoder period top
// hold length generator, typed compare tasks and error stop

`ifndef ENC_PERIOD_CHECKS_SVH
`define ENC_PERIOD_CHECKS_SVH

   logic [31:0] lfsr_state = 32'hb53ba012;   // fixed seed

   // ------------------------------------------------------------------------
   // random hold lengths
   // ------------------------------------------------------------------------
   // galois form with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] nxt;
      nxt = state >> 1;
      if (state[0]) begin
         nxt = nxt ^ 32'h80200003;
      end
      return nxt;
   endfunction

   // 8..23 cycles so the strobe always lands inside the hold
   function automatic int random_hold();
      logic [3:0] bits;
      bits = '0;
      for (int i = 0; i < 4; i++) begin
         lfsr_state = lfsr_next(lfsr_state);    // one step per bit
         bits       = {bits[2:0], lfsr_state[0]};
      end
      return 8 + int'(bits);
   endfunction

   // ------------------------------------------------------------------------
   // error stop and compares
   // ------------------------------------------------------------------------
   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Verification failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_period_word(input string name,
                                    input enc_report_pkg::period_word_t expected,
                                    input enc_report_pkg::period_word_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                 $time, name, expected, actual));
      end
   endtask

   task automatic check_position(input string name,
                                 input logic signed [enc_types_pkg::pos_width-1:0] expected,
                                 input logic signed [enc_types_pkg::pos_width-1:0] actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("FAIL time=%0t %s expected=%0d actual=%0d",
                                 $time, name, expected, actual));
      end
   endtask

   // single bit outputs such as strobe and dir
   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("FAIL time=%0t %s expected=%b actual=%b",
                                 $time, name, expected, actual));
      end
   endtask

`endif

// File: testbench/enc_period_tb.sv
// testbench for the encoder period top
// replays the stim file on a/b and checks every period word it produces

`timescale 1ns/10ps

module enc_period_tb;

   localparam string stim_path   = "testbench/enc_period_stim.txt";
   localparam int    clk_half    = 50;   // 100 ns clock
   localparam int    drive_delay = 1;    // ns after the rising edge

   logic                                       clk_fast;
   logic                                       reset;
   logic                                       a;
   logic                                       b;
   enc_report_pkg::period_word_t               period;
   logic                                       period_strobe;
   logic signed [enc_types_pkg::pos_width-1:0] position;
   logic                                       dir;

   int    fd;
   int    line_no;      // data lines only
   int    n_fields;
   string line;
   int    hold_sum;     // cycles driven since the last a rise
   int    f_a;
   int    f_b;
   int    f_hold;
   int    f_flag;
   int    f_period;
   int    f_dir;
   int    f_chg;
   int    f_ovf;
   int    f_pos;

   `include "enc_period_checks.svh"

   enc_period_top u_enc_period_top (
      .clk_fast      (clk_fast),
      .reset         (reset),
      .a             (a),
      .b             (b),
      .period        (period),
      .period_strobe (period_strobe),
      .position      (position),
      .dir           (dir)
   );

   initial begin
      clk_fast = 1'b0;
      forever #(clk_half) clk_fast = ~clk_fast;
   end

   // drive and sample point just past the edge
   task automatic next_cycle();
      @(posedge clk_fast);
      #(drive_delay);
   endtask

   // ------------------------------------------------------------------------
   // one stim line drives a/b and holds while watching for the strobe
   // flag 0 no word, 1 checked word, 2 word expected but not checked
   // ------------------------------------------------------------------------
   task automatic run_line(input int la, input int lb, input int hold, input int flag,
                           input int exp_period, input int exp_dir, input int exp_chg,
                           input int exp_ovf, input int exp_pos);
      enc_report_pkg::period_word_t exp_word;
      int                           n_hold;
      int                           span;
      bit                           seen;
      n_hold = (hold == 0) ? random_hold() : hold;
      span   = hold_sum;                       // a rise to a rise spacing
      if (la == 1 && a == 1'b0) begin
         hold_sum = 0;
      end
      exp_word             = '0;
      exp_word.valid       = 1'b1;
      exp_word.dir         = exp_dir[0];
      exp_word.dir_changed = exp_chg[0];
      exp_word.edge_sel    = 2'b00;            // a_up only
      exp_word.overflowed  = exp_ovf[0];
      exp_word.spare       = 4'd0;
      exp_word.period      = enc_types_pkg::period_width'((exp_period == 0) ? span
                                                                           : exp_period);
      a    = la[0];
      b    = lb[0];
      seen = 1'b0;
      // strobe search spans the hold cycles
      for (int cyc = 1; cyc <= n_hold; cyc++) begin
         next_cycle();
         if (period_strobe) begin
            if (flag == 0 || seen) begin
               stop_on_error($sformatf("unexpected period_strobe on stim line %0d", line_no));
            end else begin
               seen = 1'b1;
               if (flag == 1) begin
                  check_period_word("period", exp_word, period);
               end
               check_position("position", exp_pos, position);
               check_flag("dir", exp_dir[0], dir);
            end
         end
      end
      if (flag != 0 && !seen) begin
         stop_on_error($sformatf("timeout, no period_strobe within %0d cycles of stim line %0d",
                                 n_hold, line_no));
      end
      hold_sum += n_hold;
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      reset    = 1'b0;
      a        = 1'b0;
      b        = 1'b0;
      hold_sum = 0;
      line_no  = 0;
      repeat (2) @(posedge clk_fast);
      #(drive_delay);
      reset = 1'b1;
      // everything still at its reset value
      check_period_word("period", '0, period);
      check_flag("period_strobe", 1'b0, period_strobe);
      check_position("position", '0, position);

      fd = $fopen(stim_path, "r");
      if (fd == 0) begin
         stop_on_error("could not open the stim file");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;                          // header or blank
         end
         line_no++;
         n_fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d", f_a, f_b, f_hold, f_flag,
                            f_period, f_dir, f_chg, f_ovf, f_pos);
         if (n_fields != 9) begin
            stop_on_error($sformatf("stim line %0d has %0d fields, 9 expected",
                                    line_no, n_fields));
         end
         run_line(f_a, f_b, f_hold, f_flag, f_period, f_dir, f_chg, f_ovf, f_pos);
      end
      $fclose(fd);

      if (line_no > 0) begin
         $display("Verification passed");
      end else begin
         $display("no stim lines were run");
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: src/enc_period_top.sv
// encoder period top
// sync -> quadrature decode -> period count -> period word

`timescale 1ns/10ps

module enc_period_top (
   input  logic                                       clk_fast,
   input  logic                                       reset,          // async, active low
   input  logic                                       a,              // encoder line a
   input  logic                                       b,              // encoder line b
   output enc_report_pkg::period_word_t               period,         // latest period word
   output logic                                       period_strobe,  // 5 cycles after a rise
   output logic signed [enc_types_pkg::pos_width-1:0] position,
   output logic                                       dir
);

   enc_types_pkg::quad_sample_t            sample;       // synced channels
   enc_types_pkg::motion_t                 motion;       // decoded motion
   logic                                   meas_strobe;
   logic [enc_types_pkg::period_width-1:0] meas_period;
   logic                                   meas_chg;
   logic                                   meas_ovf;
   logic                                   meas_dir;

   enc_input_sync u_enc_input_sync (
      .clk_fast (clk_fast),
      .reset    (reset),
      .a        (a),
      .b        (b),
      .sample   (sample)
   );

   enc_quad_decoder u_enc_quad_decoder (
      .clk_fast (clk_fast),
      .reset    (reset),
      .sample   (sample),
      .motion   (motion)
   );

   enc_period_counter u_enc_period_counter (
      .clk_fast    (clk_fast),
      .reset       (reset),
      .motion      (motion),
      .meas_strobe (meas_strobe),
      .period      (meas_period),
      .dir_changed (meas_chg),
      .overflowed  (meas_ovf),
      .dir         (meas_dir)
   );

   enc_period_report u_enc_period_report (
      .clk_fast    (clk_fast),
      .reset       (reset),
      .meas_strobe (meas_strobe),
      .period      (meas_period),
      .dir_changed (meas_chg),
      .overflowed  (meas_ovf),
      .dir         (meas_dir),
      .word        (period),
      .word_strobe (period_strobe)
   );

   // live motion straight from the decoder
   assign position = motion.position;
   assign dir      = motion.dir;

endmodule

// File: src/enc_period_report.sv
// period report
// packs each measurement into the 32-bit period word and pulses its strobe

`timescale 1ns/10ps

module enc_period_report (
   input  logic                                   clk_fast,
   input  logic                                   reset,        // async, active low
   input  logic                                   meas_strobe,  // new measurement
   input  logic [enc_types_pkg::period_width-1:0] period,
   input  logic                                   dir_changed,
   input  logic                                   overflowed,
   input  logic                                   dir,
   output enc_report_pkg::period_word_t           word,         // held between strobes
   output logic                                   word_strobe   // one cycle per new word
);

   // -------------------------------------------------------------------------
   // word register, zero until the first measurement
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         word        <= '0;
         word_strobe <= 1'b0;
      end else begin
         word_strobe <= meas_strobe;
         if (meas_strobe) begin
            word.valid       <= 1'b1;
            word.dir         <= dir;
            word.dir_changed <= dir_changed;
            word.edge_sel    <= enc_report_pkg::edge_a_up;   // only edge timed
            word.overflowed  <= overflowed;
            word.spare       <= enc_report_pkg::spare_zero;
            word.period      <= period;
         end
      end
   end

endmodule

// File: src/enc_period_counter.sv
// period counter
// counts clk_fast cycles between a-rise strobes, saturates and flags reversals

`timescale 1ns/10ps

module enc_period_counter (
   input  logic                                   clk_fast,
   input  logic                                   reset,        // async, active low
   input  enc_types_pkg::motion_t                 motion,       // from quad decoder
   output logic                                   meas_strobe,  // one cycle, new latch
   output logic [enc_types_pkg::period_width-1:0] period,       // latched count
   output logic                                   dir_changed,  // latched reversal flag
   output logic                                   overflowed,   // latched saturation flag
   output logic                                   dir           // dir at latch time
);

   // -------------------------------------------------------------------------
   // free running state
   // -------------------------------------------------------------------------
   logic [enc_types_pkg::period_width-1:0] count;      // cycles since last a_up
   logic                                   cnt_chg;    // reversal since last a_up
   logic                                   cnt_ovf;    // saturated since last a_up
   logic                                   dir_step;   // dir seen at the last step

   // reversal seen this cycle
   logic                                   dir_flip;

   // what a latch would take this cycle, reversal wins over the count
   logic [enc_types_pkg::period_width-1:0] count_eff;
   logic                                   chg_eff;
   logic                                   ovf_eff;

   assign dir_flip = motion.step & (motion.dir != dir_step);

   always_comb begin
      if (dir_flip) begin
         count_eff = enc_types_pkg::period_max;   // reads as zero velocity
         chg_eff   = 1'b1;
         ovf_eff   = 1'b0;
      end else begin
         count_eff = count;
         chg_eff   = cnt_chg;
         ovf_eff   = cnt_ovf;
      end
   end

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         count    <= '0;
         cnt_chg  <= 1'b0;
         cnt_ovf  <= 1'b0;
         dir_step <= 1'b0;
      end else begin
         if (motion.step) begin
            dir_step <= motion.dir;
         end
         if (motion.a_up) begin
            count   <= {{(enc_types_pkg::period_width-1){1'b0}}, 1'b1};  // restart at 1
            cnt_chg <= 1'b0;
            cnt_ovf <= 1'b0;
         end else if (dir_flip) begin
            count   <= enc_types_pkg::period_max;
            cnt_chg <= 1'b1;
            cnt_ovf <= 1'b0;
         end else if (count != enc_types_pkg::period_max) begin
            count <= count + 1'b1;
            if (count == enc_types_pkg::period_max - 1'b1) begin
               cnt_ovf <= 1'b1;                   // about to saturate
            end
         end
         // at max with no a_up: hold
      end
   end

   // -------------------------------------------------------------------------
   // latch on a_up, strobe in the following cycle
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         meas_strobe <= 1'b0;
         period      <= '0;
         dir_changed <= 1'b0;
         overflowed  <= 1'b0;
         dir         <= 1'b0;
      end else begin
         meas_strobe <= motion.a_up;
         if (motion.a_up) begin
            period      <= count_eff;
            dir_changed <= chg_eff;
            overflowed  <= ovf_eff;
            dir         <= motion.dir;
         end
      end
   end

endmodule

// File: src/enc_quad_decoder.sv
// quadrature decoder
// turns a/b transitions into direction, signed position and the a-rise strobe

`timescale 1ns/10ps

module enc_quad_decoder (
   input  logic                        clk_fast,
   input  logic                        reset,    // async, active low
   input  enc_types_pkg::quad_sample_t sample,   // from input sync
   output enc_types_pkg::motion_t      motion    // registered, 1 cycle behind sample
);

   logic [1:0] ab_prev;     // a/b state at the last seen edge
   logic [1:0] ab_cur;      // current synced a/b
   logic       any_edge;    // some channel moved this cycle
   logic       step_fwd;    // legal step, a leads b
   logic       step_rev;    // legal step, b leads a

   assign ab_cur   = {sample.a, sample.b};
   assign any_edge = sample.a_rise | sample.a_fall | sample.b_rise | sample.b_fall;

   // -------------------------------------------------------------------------
   // gray code transition table
   // forward : 00 -> 10 -> 11 -> 01 -> 00
   // reverse : 00 -> 01 -> 11 -> 10 -> 00
   // both bits changing is illegal and ignored
   // -------------------------------------------------------------------------
   always_comb begin
      step_fwd = 1'b0;
      step_rev = 1'b0;
      if (any_edge) begin
         case ({ab_prev, ab_cur})
            4'b00_10,
            4'b10_11,
            4'b11_01,
            4'b01_00: step_fwd = 1'b1;   // a leads b
            4'b00_01,
            4'b01_11,
            4'b11_10,
            4'b10_00: step_rev = 1'b1;   // b leads a
            default: begin
               step_fwd = 1'b0;          // double change, no step
               step_rev = 1'b0;
            end
         endcase
      end
   end

   // previous state follows every edge, also illegal ones, so we resync
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         ab_prev <= 2'b00;
      end else if (any_edge) begin
         ab_prev <= ab_cur;
      end
   end

   // -------------------------------------------------------------------------
   // motion register
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         motion <= '0;
      end else begin
         motion.step <= step_fwd | step_rev;
         motion.a_up <= sample.a_rise;            // passed through, 1 cycle late
         if (step_fwd) begin
            motion.dir      <= 1'b0;
            motion.position <= motion.position + 1'b1;
         end else if (step_rev) begin
            motion.dir      <= 1'b1;
            motion.position <= motion.position - 1'b1;
         end
         // no step: old dir and position hold
      end
   end

endmodule

// File: src/enc_input_sync.sv
// encoder input synchronizer
// brings a and b into clk_fast and flags their rising and falling edges

`timescale 1ns/10ps

module enc_input_sync (
   input  logic                        clk_fast,
   input  logic                        reset,    // async, active low
   input  logic                        a,        // raw encoder line a
   input  logic                        b,        // raw encoder line b
   output enc_types_pkg::quad_sample_t sample    // synced levels and edge strobes
);

   // -------------------------------------------------------------------------
   // two flop synchronizer per channel
   // -------------------------------------------------------------------------
   logic a_meta;   // first stage, may go metastable
   logic b_meta;
   logic a_sync;   // second stage, safe to use
   logic b_sync;

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         a_meta <= 1'b0;
         b_meta <= 1'b0;
         a_sync <= 1'b0;
         b_sync <= 1'b0;
      end else begin
         a_meta <= a;
         b_meta <= b;
         a_sync <= a_meta;
         b_sync <= b_meta;
      end
   end

   // -------------------------------------------------------------------------
   // edge register
   // sample.a / sample.b hold the previous synced level for the compare
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         sample <= '0;
      end else begin
         sample.a      <= a_sync;
         sample.b      <= b_sync;
         sample.a_rise <= a_sync & ~sample.a;    // third cycle after first sample
         sample.a_fall <= ~a_sync & sample.a;
         sample.b_rise <= b_sync & ~sample.b;
         sample.b_fall <= ~b_sync & sample.b;
      end
   end

endmodule

// File: src/enc_report_pkg.sv
// period report layout
// 32-bit period word as seen by the host side and its field codes

package enc_report_pkg;

   // edge select codes, only a_up is measured here
   localparam logic [1:0] edge_a_up = 2'b00;

   // spare field, reads as zero
   localparam logic [3:0] spare_zero = 4'd0;

   // -------------------------------------------------------------------------
   // period word, msb first
   //   [31]    valid
   //   [30]    dir
   //   [29]    dir_changed
   //   [28:27] edge_sel
   //   [26]    overflowed
   //   [25:22] spare
   //   [21:0]  period in clk_fast cycles
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic                                   valid;        // set once a word is out
      logic                                   dir;          // direction at latch time
      logic                                   dir_changed;  // reversal, period forced max
      logic [1:0]                             edge_sel;     // which edge was timed
      logic                                   overflowed;   // counter ran into max
      logic [3:0]                             spare;
      logic [enc_types_pkg::period_width-1:0] period;
   } period_word_t;

endpackage

// File: src/enc_types_pkg.sv
// encoder side types
// widths, sampled channel bundle and decoded motion for the period path

package enc_types_pkg;

   // -------------------------------------------------------------------------
   // widths
   // -------------------------------------------------------------------------
   localparam int period_width = 22;                     // clk_fast counts per a cycle
   localparam logic [period_width-1:0] period_max = '1;  // 22'h3FFFFF, saturation value
   localparam int pos_width = 32;                        // signed position counter

   // -------------------------------------------------------------------------
   // synchronized channels plus single cycle edge strobes
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic a;        // synced level of channel a
      logic b;        // synced level of channel b
      logic a_rise;   // a went 0 -> 1
      logic a_fall;   // a went 1 -> 0
      logic b_rise;
      logic b_fall;
   } quad_sample_t;

   // -------------------------------------------------------------------------
   // decoder result
   // dir 0 : a leads b, a-up -> b-up -> a-down -> b-down
   // dir 1 : b leads a, b-up -> a-up -> b-down -> a-down
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic                        dir;       // last legal step direction
      logic                        step;      // pulse on any legal transition
      logic                        a_up;      // pulse on rising edge of a
      logic signed [pos_width-1:0] position;  // up for dir 0, down for dir 1
   } motion_t;

endpackage
